// File: compile.f
design/lsu_pkg.sv
design/lsu_sq.sv
design/lsu_ld_unit.sv
design/lsu_mem_arb.sv
design/lsu_dmem.sv
design/lsu_top.sv
tb/lsu_tb.sv

// File: Makefile
# Verilator build and run of the load/store unit testbench

SIM       := verilator
SIM_FLAGS := --binary --timing --assert
TOP       := lsu_tb
FILELIST  := compile.f
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/lsu_tb.sv
// Directed testbench for the store side of the load/store unit
// Expected load values come from a byte-array model that is updated on commit
// Loads see committed memory only, so a store counts as done once a load returns it
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

    // About 250 cycles of tests, so the limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic               clk;
    logic               n_rst;
    logic               i_alloc_en;
    lsu_pkg::lsu_func_t i_alloc_func;
    lsu_pkg::lsu_tag_t  i_alloc_tag;
    lsu_pkg::lsu_addr_t i_alloc_addr;
    lsu_pkg::lsu_data_t i_alloc_data;
    logic               o_full;
    logic               i_rob_retire_en;
    lsu_pkg::lsu_tag_t  i_rob_retire_tag;
    logic               o_rob_retire_ack;
    logic               i_flush;
    logic               i_ld_en;
    lsu_pkg::lsu_func_t i_ld_func;
    lsu_pkg::lsu_addr_t i_ld_addr;
    logic               o_ld_busy;
    logic               o_ld_valid;
    lsu_pkg::lsu_data_t o_ld_data;

    // Reference memory, one entry per byte address
    logic [7:0]         ref_mem [256];

    // Stores waiting for commit, indexed by their tag
    lsu_pkg::lsu_func_t pend_func [16];
    lsu_pkg::lsu_addr_t pend_addr [16];
    lsu_pkg::lsu_data_t pend_data [16];

    integer seed = 71;
    int     checks = 0;
    int     errors = 0;
    int     err_mark = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    lsu_top u_lsu_top (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_alloc_en       (i_alloc_en),
        .i_alloc_func     (i_alloc_func),
        .i_alloc_tag      (i_alloc_tag),
        .i_alloc_addr     (i_alloc_addr),
        .i_alloc_data     (i_alloc_data),
        .o_full           (o_full),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .o_rob_retire_ack (o_rob_retire_ack),
        .i_flush          (i_flush),
        .i_ld_en          (i_ld_en),
        .i_ld_func        (i_ld_func),
        .i_ld_addr        (i_ld_addr),
        .o_ld_busy        (o_ld_busy),
        .o_ld_valid       (o_ld_valid),
        .o_ld_data        (o_ld_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog for a DUT that never answers
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic int func_bytes(input lsu_pkg::lsu_func_t func);
        case (func)
            lsu_pkg::LSU_FUNC_BYTE: return 1;
            lsu_pkg::LSU_FUNC_HALF: return 2;
            default:                return 4;
        endcase
    endfunction

    // Byte k of the store data lands at byte address addr + k
    task automatic model_store(input lsu_pkg::lsu_func_t func, input lsu_pkg::lsu_addr_t addr,
                               input lsu_pkg::lsu_data_t data);
        for (int k = 0; k < func_bytes(func); k++) begin
            ref_mem[addr + 8'(k)] = data[8*k +: 8];
        end
    endtask

    // Little-endian gather of the accessed bytes, then sign extension by size
    function automatic lsu_pkg::lsu_data_t model_load(input lsu_pkg::lsu_func_t func,
                                                      input lsu_pkg::lsu_addr_t addr);
        lsu_pkg::lsu_data_t v;
        v = '0;
        for (int k = 0; k < func_bytes(func); k++) begin
            v[8*k +: 8] = ref_mem[addr + 8'(k)];
        end
        if (func == lsu_pkg::LSU_FUNC_BYTE) begin
            v = {{24{v[7]}}, v[7:0]};
        end else if (func == lsu_pkg::LSU_FUNC_HALF) begin
            v = {{16{v[15]}}, v[15:0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %-20s ok", name);
        end else begin
            $display("test %-20s %0d errors", name, errors - err_mark);
            tests_failed++;
        end
        err_mark = errors;
    endtask

    // All driving tasks start and end on a falling edge
    task automatic alloc_store(input lsu_pkg::lsu_func_t func, input lsu_pkg::lsu_tag_t tag,
                               input lsu_pkg::lsu_addr_t addr, input lsu_pkg::lsu_data_t data);
        pend_func[tag] = func;
        pend_addr[tag] = addr;
        pend_data[tag] = data;
        i_alloc_en     = 1'b1;
        i_alloc_func   = func;
        i_alloc_tag    = tag;
        i_alloc_addr   = addr;
        i_alloc_data   = data;
        @(negedge clk);
        i_alloc_en = 1'b0;
    endtask

    // The ack belongs to the cycle after the commit edge
    task automatic commit_store(input lsu_pkg::lsu_tag_t tag, input logic expect_ack);
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = tag;
        @(negedge clk);
        i_rob_retire_en = 1'b0;
        check_value("o_rob_retire_ack", 32'(o_rob_retire_ack), 32'(expect_ack));
        if (expect_ack) begin
            model_store(pend_func[tag], pend_addr[tag], pend_data[tag]);
        end
    endtask

    task automatic pulse_flush();
        i_flush = 1'b1;
        @(negedge clk);
        i_flush = 1'b0;
    endtask

    // Returns on the falling edge of the o_ld_valid cycle
    task automatic run_load(input lsu_pkg::lsu_func_t func, input lsu_pkg::lsu_addr_t addr,
                            output lsu_pkg::lsu_data_t got);
        i_ld_en   = 1'b1;
        i_ld_func = func;
        i_ld_addr = addr;
        @(negedge clk);
        i_ld_en = 1'b0;
        while (!o_ld_valid) @(negedge clk);
        got = o_ld_data;
    endtask

    task automatic check_load(input lsu_pkg::lsu_func_t func, input lsu_pkg::lsu_addr_t addr);
        lsu_pkg::lsu_data_t got;
        run_load(func, addr, got);
        check_value("o_ld_data", got, model_load(func, addr));
    endtask

    // Polls with spaced loads so that a committed store finds a free memory cycle
    task automatic wait_store_landed(input lsu_pkg::lsu_func_t func,
                                     input lsu_pkg::lsu_addr_t addr);
        lsu_pkg::lsu_data_t got;
        bit                 landed;
        landed = 1'b0;
        for (int tries = 0; tries < 16 && !landed; tries++) begin
            run_load(func, addr, got);
            landed = (got == model_load(func, addr));
            @(negedge clk);
        end
        checks++;
        assert (landed) else begin
            $display("Committed store to address 0x%h never reached memory", addr);
            errors++;
        end
    endtask

    task automatic word_store_commit();
        alloc_store(lsu_pkg::LSU_FUNC_WORD, 4'd3, 8'h10, $random(seed));
        commit_store(4'd3, 1'b1);
        wait_store_landed(lsu_pkg::LSU_FUNC_WORD, 8'h10);
        check_load(lsu_pkg::LSU_FUNC_WORD, 8'h10);
        finish_test("word_store_commit");
    endtask

    // Negative byte in lane 1 and positive halfword in lanes 2 and 3
    task automatic mixed_lane_stores();
        alloc_store(lsu_pkg::LSU_FUNC_BYTE, 4'd1, 8'h21, $random(seed) | 32'h80);
        alloc_store(lsu_pkg::LSU_FUNC_HALF, 4'd2, 8'h22, $random(seed) & 32'h7fff);
        commit_store(4'd1, 1'b1);
        commit_store(4'd2, 1'b1);
        wait_store_landed(lsu_pkg::LSU_FUNC_WORD, 8'h20);
        check_load(lsu_pkg::LSU_FUNC_BYTE, 8'h20);
        check_load(lsu_pkg::LSU_FUNC_BYTE, 8'h21);
        check_load(lsu_pkg::LSU_FUNC_BYTE, 8'h23);
        check_load(lsu_pkg::LSU_FUNC_HALF, 8'h20);
        check_load(lsu_pkg::LSU_FUNC_HALF, 8'h22);
        check_load(lsu_pkg::LSU_FUNC_WORD, 8'h20);
        finish_test("mixed_lane_stores");
    endtask

    task automatic flush_speculative();
        alloc_store(lsu_pkg::LSU_FUNC_WORD, 4'd4, 8'h30, $random(seed));
        alloc_store(lsu_pkg::LSU_FUNC_WORD, 4'd5, 8'h34, $random(seed));
        commit_store(4'd4, 1'b1);
        pulse_flush();
        // The flushed store is gone, so its tag finds no entry and nothing reaches memory
        commit_store(4'd5, 1'b0);
        wait_store_landed(lsu_pkg::LSU_FUNC_WORD, 8'h30);
        check_load(lsu_pkg::LSU_FUNC_WORD, 8'h30);
        check_load(lsu_pkg::LSU_FUNC_WORD, 8'h34);
        finish_test("flush_speculative");
    endtask

    task automatic fill_queue();
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            alloc_store(lsu_pkg::LSU_FUNC_WORD, 4'(6 + i), 8'(8'h40 + 4 * i), $random(seed));
        end
        check_value("o_full", 32'(o_full), 32'h1);
        commit_store(4'd7, 1'b1);
        wait_store_landed(lsu_pkg::LSU_FUNC_WORD, 8'h44);
        check_value("o_full", 32'(o_full), 32'h0);
        // The other three never commit and leave with the flush
        pulse_flush();
        commit_store(4'd6, 1'b0);
        commit_store(4'd8, 1'b0);
        check_load(lsu_pkg::LSU_FUNC_WORD, 8'h40);
        check_load(lsu_pkg::LSU_FUNC_WORD, 8'h48);
        finish_test("fill_queue");
    endtask

    // Back-to-back loads keep winning the memory, so the store is retried until they stop
    task automatic loads_block_store();
        lsu_pkg::lsu_data_t old_val;
        lsu_pkg::lsu_data_t new_val;
        lsu_pkg::lsu_data_t got;
        bit                 landed;
        old_val = model_load(lsu_pkg::LSU_FUNC_WORD, 8'h60);
        new_val = $random(seed);
        if (new_val == old_val) begin
            new_val = ~new_val;
        end
        landed = 1'b0;
        alloc_store(lsu_pkg::LSU_FUNC_WORD, 4'd12, 8'h60, new_val);
        commit_store(4'd12, 1'b1);
        for (int i = 0; i < 6; i++) begin
            run_load(lsu_pkg::LSU_FUNC_WORD, 8'h60, got);
            checks++;
            assert ((got == old_val && !landed) || got == new_val) else begin
                $display("FAILED o_ld_data: got 0x%h, expected 0x%h", got, old_val);
                errors++;
            end
            landed = landed || (got == new_val);
        end
        wait_store_landed(lsu_pkg::LSU_FUNC_WORD, 8'h60);
        check_load(lsu_pkg::LSU_FUNC_WORD, 8'h60);
        finish_test("loads_block_store");
    endtask

    task automatic unknown_tag_commit();
        alloc_store(lsu_pkg::LSU_FUNC_WORD, 4'd10, 8'h50, $random(seed));
        commit_store(4'd11, 1'b0);
        pulse_flush();
        repeat (4) @(negedge clk);
        check_load(lsu_pkg::LSU_FUNC_WORD, 8'h50);
        finish_test("unknown_tag_commit");
    endtask

    initial begin
        n_rst            = 1'b0;
        i_alloc_en       = 1'b0;
        i_alloc_func     = lsu_pkg::LSU_FUNC_WORD;
        i_alloc_tag      = '0;
        i_alloc_addr     = '0;
        i_alloc_data     = '0;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;
        i_flush          = 1'b0;
        i_ld_en          = 1'b0;
        i_ld_func        = lsu_pkg::LSU_FUNC_WORD;
        i_ld_addr        = '0;
        for (int a = 0; a < 256; a++) begin
            ref_mem[a] = 8'h00;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_value("o_full", 32'(o_full), 32'h0);
        check_value("o_rob_retire_ack", 32'(o_rob_retire_ack), 32'h0);
        check_value("o_ld_busy", 32'(o_ld_busy), 32'h0);
        check_value("o_ld_valid", 32'(o_ld_valid), 32'h0);
        n_rst = 1'b1;
        finish_test("reset");
        word_store_commit();
        mixed_lane_stores();
        flush_speculative();
        fill_queue();
        loads_block_store();
        unknown_tag_commit();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/lsu_top.sv
// Store side of the load/store unit: store queue and load port share one memory
// Loads have priority, so a steady load stream delays committed stores
// There is no store-to-load forwarding between the two paths
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
    input  logic               clk,
    input  logic               n_rst,

    input  logic               i_alloc_en,
    input  lsu_pkg::lsu_func_t i_alloc_func,
    input  lsu_pkg::lsu_tag_t  i_alloc_tag,
    input  lsu_pkg::lsu_addr_t i_alloc_addr,
    input  lsu_pkg::lsu_data_t i_alloc_data,
    output logic               o_full,

    input  logic               i_rob_retire_en,
    input  lsu_pkg::lsu_tag_t  i_rob_retire_tag,
    output logic               o_rob_retire_ack,

    input  logic               i_flush,

    input  logic               i_ld_en,
    input  lsu_pkg::lsu_func_t i_ld_func,
    input  lsu_pkg::lsu_addr_t i_ld_addr,
    output logic               o_ld_busy,
    output logic               o_ld_valid,
    output lsu_pkg::lsu_data_t o_ld_data
);

    // Store path between queue and arbiter
    logic                   st_req;
    lsu_pkg::lsu_sq_sel_t   st_sel;
    lsu_pkg::lsu_func_t     st_func;
    lsu_pkg::lsu_addr_t     st_addr;
    lsu_pkg::lsu_data_t     st_data;
    logic                   st_update_en;
    lsu_pkg::lsu_sq_sel_t   st_update_sel;
    logic                   st_update_retry;

    // Load path between load port and arbiter
    logic                   rd_req;
    lsu_pkg::lsu_func_t     rd_func;
    lsu_pkg::lsu_addr_t     rd_addr;
    logic                   rd_grant;

    // Memory side
    logic                   mem_en;
    logic                   mem_we;
    lsu_pkg::lsu_word_idx_t mem_idx;
    lsu_pkg::lsu_be_t       mem_be;
    lsu_pkg::lsu_data_t     mem_wdata;
    lsu_pkg::lsu_data_t     mem_rdata;

    lsu_sq u_sq (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .o_full           (o_full),
        .i_alloc_en       (i_alloc_en),
        .i_alloc_func     (i_alloc_func),
        .i_alloc_tag      (i_alloc_tag),
        .i_alloc_addr     (i_alloc_addr),
        .i_alloc_data     (i_alloc_data),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .o_rob_retire_ack (o_rob_retire_ack),
        .o_st_req         (st_req),
        .o_st_sel         (st_sel),
        .o_st_func        (st_func),
        .o_st_addr        (st_addr),
        .o_st_data        (st_data),
        .i_update_en      (st_update_en),
        .i_update_sel     (st_update_sel),
        .i_update_retry   (st_update_retry)
    );

    lsu_ld_unit u_ld_unit (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_ld_en    (i_ld_en),
        .i_ld_func  (i_ld_func),
        .i_ld_addr  (i_ld_addr),
        .o_ld_busy  (o_ld_busy),
        .o_rd_req   (rd_req),
        .o_rd_func  (rd_func),
        .o_rd_addr  (rd_addr),
        .i_rd_grant (rd_grant),
        .i_rd_word  (mem_rdata),
        .o_ld_valid (o_ld_valid),
        .o_ld_data  (o_ld_data)
    );

    lsu_mem_arb u_mem_arb (
        .i_rd_req          (rd_req),
        .i_rd_func         (rd_func),
        .i_rd_addr         (rd_addr),
        .o_rd_grant        (rd_grant),
        .i_st_req          (st_req),
        .i_st_sel          (st_sel),
        .i_st_func         (st_func),
        .i_st_addr         (st_addr),
        .i_st_data         (st_data),
        .o_st_update_en    (st_update_en),
        .o_st_update_sel   (st_update_sel),
        .o_st_update_retry (st_update_retry),
        .o_mem_en          (mem_en),
        .o_mem_we          (mem_we),
        .o_mem_idx         (mem_idx),
        .o_mem_be          (mem_be),
        .o_mem_wdata       (mem_wdata)
    );

    lsu_dmem u_dmem (
        .clk     (clk),
        .i_en    (mem_en),
        .i_we    (mem_we),
        .i_idx   (mem_idx),
        .i_be    (mem_be),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: design/lsu_dmem.sv
// Word-organized data memory with byte-lane writes
// Reads are registered, so data is ready the cycle after the read
// Contents start at zero at power-up; there is no reset port
`timescale 1ns/10ps
`default_nettype none

module lsu_dmem (
    input  logic                   clk,
    input  logic                   i_en,
    input  logic                   i_we,
    input  lsu_pkg::lsu_word_idx_t i_idx,
    input  lsu_pkg::lsu_be_t       i_be,
    input  lsu_pkg::lsu_data_t     i_wdata,
    output lsu_pkg::lsu_data_t     o_rdata
);

    lsu_pkg::lsu_data_t mem [lsu_pkg::MEM_WORDS];

    initial begin
        for (int w = 0; w < lsu_pkg::MEM_WORDS; w++) begin
            mem[w] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en && i_we) begin
            // Only the enabled lanes change
            for (int b = 0; b < 4; b++) begin
                if (i_be[b]) begin
                    mem[i_idx][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
        // The read word holds until the next read
        if (i_en && !i_we) begin
            o_rdata <= mem[i_idx];
        end
    end

endmodule

`default_nettype wire

// File: design/lsu_mem_arb.sv
// Fixed-priority memory arbiter where loads always win
// A store that meets a load is told to retry and is not written
// Store data arrives right-aligned and is moved into its byte lanes here
`timescale 1ns/10ps
`default_nettype none

module lsu_mem_arb (
    input  logic                  i_rd_req,
    input  lsu_pkg::lsu_func_t    i_rd_func,
    input  lsu_pkg::lsu_addr_t    i_rd_addr,
    output logic                  o_rd_grant,

    input  logic                  i_st_req,
    input  lsu_pkg::lsu_sq_sel_t  i_st_sel,
    input  lsu_pkg::lsu_func_t    i_st_func,
    input  lsu_pkg::lsu_addr_t    i_st_addr,
    input  lsu_pkg::lsu_data_t    i_st_data,
    output logic                  o_st_update_en,
    output lsu_pkg::lsu_sq_sel_t  o_st_update_sel,
    output logic                  o_st_update_retry,

    output logic                  o_mem_en,
    output logic                  o_mem_we,
    output lsu_pkg::lsu_word_idx_t o_mem_idx,
    output lsu_pkg::lsu_be_t      o_mem_be,
    output lsu_pkg::lsu_data_t    o_mem_wdata
);

    logic st_win;

    // Byte enables for an access of the given size at the given byte offset
    function automatic lsu_pkg::lsu_be_t lane_mask(input lsu_pkg::lsu_func_t func,
                                                   input logic [1:0] offset);
        lsu_pkg::lsu_be_t mask;
        case (func)
            lsu_pkg::LSU_FUNC_BYTE: mask = 4'b0001;
            lsu_pkg::LSU_FUNC_HALF: mask = 4'b0011;
            default:                mask = 4'b1111;
        endcase
        return mask << offset;
    endfunction

    assign o_rd_grant = i_rd_req;
    assign st_win     = i_st_req && !i_rd_req;

    // Every launched store gets an answer in the same cycle
    assign o_st_update_en    = i_st_req;
    assign o_st_update_sel   = i_st_sel;
    assign o_st_update_retry = i_st_req && i_rd_req;

    assign o_mem_en    = i_rd_req || i_st_req;
    assign o_mem_we    = st_win;
    assign o_mem_idx   = i_rd_req ? i_rd_addr[7:2] : i_st_addr[7:2];
    assign o_mem_be    = i_rd_req ? lane_mask(i_rd_func, i_rd_addr[1:0]) :
                                    lane_mask(i_st_func, i_st_addr[1:0]);
    assign o_mem_wdata = i_st_data << {i_st_addr[1:0], 3'b000};

endmodule

`default_nettype wire

// File: design/lsu_ld_unit.sv
// Single load port; one load is in flight at a time
// Loads read committed memory only and never see queued stores
// Addresses must be aligned to the access size
`timescale 1ns/10ps
`default_nettype none

module lsu_ld_unit (
    input  logic               clk,
    input  logic               n_rst,

    input  logic               i_ld_en,
    input  lsu_pkg::lsu_func_t i_ld_func,
    input  lsu_pkg::lsu_addr_t i_ld_addr,
    output logic               o_ld_busy,

    output logic               o_rd_req,
    output lsu_pkg::lsu_func_t o_rd_func,
    output lsu_pkg::lsu_addr_t o_rd_addr,
    input  logic               i_rd_grant,
    input  lsu_pkg::lsu_data_t i_rd_word,

    output logic               o_ld_valid,
    output lsu_pkg::lsu_data_t o_ld_data
);

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_REQ,
        LD_RET
    } ld_state_t;

    ld_state_t          state;
    ld_state_t          state_nxt;
    lsu_pkg::lsu_func_t ld_func;
    lsu_pkg::lsu_addr_t ld_addr;
    lsu_pkg::lsu_data_t shifted;
    logic               accept;

    // A new load can enter while the previous one returns its data
    assign o_ld_busy = (state == LD_REQ);
    assign accept    = i_ld_en && !o_ld_busy;

    always_comb begin
        state_nxt = state;
        case (state)
            LD_IDLE: if (accept) state_nxt = LD_REQ;
            LD_REQ:  if (i_rd_grant) state_nxt = LD_RET;
            LD_RET:  state_nxt = accept ? LD_REQ : LD_IDLE;
            default: state_nxt = LD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= LD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Hold the request fields until the memory takes them
    always_ff @(posedge clk) begin
        if (accept) begin
            ld_func <= i_ld_func;
            ld_addr <= i_ld_addr;
        end
    end

    assign o_rd_req  = (state == LD_REQ);
    assign o_rd_func = ld_func;
    assign o_rd_addr = ld_addr;

    // Bring the addressed lane down to bit 0, then sign-extend by size
    assign shifted = i_rd_word >> {ld_addr[1:0], 3'b000};

    always_comb begin
        case (ld_func)
            lsu_pkg::LSU_FUNC_BYTE: o_ld_data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LSU_FUNC_HALF: o_ld_data = {{16{shifted[15]}}, shifted[15:0]};
            default:                o_ld_data = shifted;
        endcase
    end

    // The memory word is ready the cycle after the grant
    assign o_ld_valid = (state == LD_RET);

    a_ld_aligned: assert property (@(posedge clk) disable iff (!n_rst)
        accept |-> (i_ld_func == lsu_pkg::LSU_FUNC_BYTE) ||
                   (i_ld_func == lsu_pkg::LSU_FUNC_HALF && !i_ld_addr[0]) ||
                   (i_ld_func == lsu_pkg::LSU_FUNC_WORD && i_ld_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: design/lsu_sq.sv
// Store queue holding speculative stores until the ROB commits them by tag
// Committed stores launch to memory lowest slot first, not in allocation order
// A flush drops speculative stores; committed ones still drain to memory
// Allocating while full is not allowed and the request is dropped
`timescale 1ns/10ps
`default_nettype none

module lsu_sq (
    input  logic                 clk,
    input  logic                 n_rst,

    input  logic                 i_flush,
    output logic                 o_full,

    // New store from the issue side
    input  logic                 i_alloc_en,
    input  lsu_pkg::lsu_func_t   i_alloc_func,
    input  lsu_pkg::lsu_tag_t    i_alloc_tag,
    input  lsu_pkg::lsu_addr_t   i_alloc_addr,
    input  lsu_pkg::lsu_data_t   i_alloc_data,

    // ROB commit by tag
    input  logic                 i_rob_retire_en,
    input  lsu_pkg::lsu_tag_t    i_rob_retire_tag,
    output logic                 o_rob_retire_ack,

    // Store launched toward the memory arbiter
    output logic                 o_st_req,
    output lsu_pkg::lsu_sq_sel_t o_st_sel,
    output lsu_pkg::lsu_func_t   o_st_func,
    output lsu_pkg::lsu_addr_t   o_st_addr,
    output lsu_pkg::lsu_data_t   o_st_data,

    // Result of the launched store, returned in the same cycle as o_st_req
    input  logic                 i_update_en,
    input  lsu_pkg::lsu_sq_sel_t i_update_sel,
    input  logic                 i_update_retry
);

    // Slot payload
    lsu_pkg::lsu_func_t   slot_func [lsu_pkg::SQ_DEPTH];
    lsu_pkg::lsu_addr_t   slot_addr [lsu_pkg::SQ_DEPTH];
    lsu_pkg::lsu_data_t   slot_data [lsu_pkg::SQ_DEPTH];
    lsu_pkg::lsu_tag_t    slot_tag  [lsu_pkg::SQ_DEPTH];

    // Slot control bits, one bit per slot
    lsu_pkg::lsu_sq_sel_t slot_valid;
    lsu_pkg::lsu_sq_sel_t slot_nonspec;
    lsu_pkg::lsu_sq_sel_t slot_launched;

    lsu_pkg::lsu_sq_sel_t free_vec;
    lsu_pkg::lsu_sq_sel_t alloc_sel;
    lsu_pkg::lsu_sq_sel_t rob_match;
    lsu_pkg::lsu_sq_sel_t retirable;
    lsu_pkg::lsu_sq_sel_t launch_sel;
    lsu_pkg::lsu_sq_sel_t upd_done;
    lsu_pkg::lsu_sq_sel_t upd_retry;

    lsu_pkg::lsu_func_t   launch_func;
    lsu_pkg::lsu_addr_t   launch_addr;
    lsu_pkg::lsu_data_t   launch_data;

    assign free_vec = ~slot_valid;
    assign o_full   = ~|free_vec;

    // Lowest free slot takes the new store
    assign alloc_sel = (i_alloc_en && !o_full) ?
                       (free_vec & ~(free_vec - lsu_pkg::lsu_sq_sel_t'(1))) : '0;

    // A slot can launch once committed, while not already in flight
    assign retirable  = slot_valid & slot_nonspec & ~slot_launched;
    assign launch_sel = retirable & ~(retirable - lsu_pkg::lsu_sq_sel_t'(1));

    // Split the update into a completion and a retry
    assign upd_done  = (i_update_en && !i_update_retry) ? i_update_sel : '0;
    assign upd_retry = (i_update_en &&  i_update_retry) ? i_update_sel : '0;

    // Tag compare against every valid slot
    always_comb begin
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            rob_match[i] = i_rob_retire_en && slot_valid[i] && (slot_tag[i] == i_rob_retire_tag);
        end
    end

    // One-hot mux of the launching slot's payload
    always_comb begin
        launch_func = lsu_pkg::LSU_FUNC_BYTE;
        launch_addr = '0;
        launch_data = '0;
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            if (launch_sel[i]) begin
                launch_func = slot_func[i];
                launch_addr = slot_addr[i];
                launch_data = slot_data[i];
            end
        end
    end

    // Slot control and the registered request and ack strobes
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            slot_valid       <= '0;
            slot_nonspec     <= '0;
            slot_launched    <= '0;
            o_st_req         <= 1'b0;
            o_rob_retire_ack <= 1'b0;
        end else begin
            o_rob_retire_ack <= |rob_match;
            o_st_req         <= |launch_sel;
            for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
                if (alloc_sel[i]) begin
                    slot_valid[i]    <= 1'b1;
                    slot_nonspec[i]  <= 1'b0;
                    slot_launched[i] <= 1'b0;
                end else if (upd_done[i]) begin
                    // The store reached memory, so the slot is free again
                    slot_valid[i]    <= 1'b0;
                    slot_nonspec[i]  <= 1'b0;
                    slot_launched[i] <= 1'b0;
                end else begin
                    // Committed stays set until the slot is freed
                    if (rob_match[i]) begin
                        slot_nonspec[i] <= 1'b1;
                    end
                    if (launch_sel[i]) begin
                        slot_launched[i] <= 1'b1;
                    end else if (upd_retry[i]) begin
                        // Lost arbitration, so the slot becomes retirable again
                        slot_launched[i] <= 1'b0;
                    end
                end
                // Flush drops everything still speculative, including this cycle's allocation
                if (i_flush && !slot_nonspec[i]) begin
                    slot_valid[i] <= 1'b0;
                end
            end
        end
    end

    // Payload of new stores and of the launched store
    always_ff @(posedge clk) begin
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            if (alloc_sel[i]) begin
                slot_func[i] <= i_alloc_func;
                slot_addr[i] <= i_alloc_addr;
                slot_data[i] <= i_alloc_data;
                slot_tag[i]  <= i_alloc_tag;
            end
        end
        o_st_sel  <= launch_sel;
        o_st_func <= launch_func;
        o_st_addr <= launch_addr;
        o_st_data <= launch_data;
    end

    // The issue side must watch o_full before allocating
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        i_alloc_en |-> !o_full);

    // The ROB never has two live stores with one tag
    a_tag_unique: assert property (@(posedge clk) disable iff (!n_rst)
        $onehot0(rob_match));

    // The arbiter only reports on a store that is in flight
    a_update_launched: assert property (@(posedge clk) disable iff (!n_rst)
        i_update_en |-> $onehot(i_update_sel) && ((i_update_sel & slot_launched) == i_update_sel));

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
// Shared types and sizes for the store-side load/store unit
// Addresses are byte addresses into a small word-organized data memory
// Store data and load results are right-aligned in a 32-bit word
`default_nettype none

package lsu_pkg;

    // Byte address covering the whole data memory
    typedef logic [7:0]  lsu_addr_t;

    // Data word as seen by stores and loads
    typedef logic [31:0] lsu_data_t;

    // Reorder-buffer tag carried by each store
    typedef logic [3:0]  lsu_tag_t;

    // Access size of a load or store
    typedef enum logic [1:0] {
        LSU_FUNC_BYTE = 2'b00,
        LSU_FUNC_HALF = 2'b01,
        LSU_FUNC_WORD = 2'b10
    } lsu_func_t;

    // Number of store queue slots
    localparam int SQ_DEPTH = 4;

    // One-hot select of a store queue slot
    typedef logic [SQ_DEPTH-1:0] lsu_sq_sel_t;

    // Data memory size in 32-bit words
    localparam int MEM_WORDS = 64;

    // Word index into the data memory, which is the byte address without its low two bits
    typedef logic [$clog2(MEM_WORDS)-1:0] lsu_word_idx_t;

    // Per-byte lane enables of one word
    typedef logic [3:0] lsu_be_t;

endpackage

`default_nettype wire
